// File: source/badge_pkg.sv
package badge_pkg;

  // Bus and RAM geometry
  localparam int DATA_W      = 16;   // APB data, all registers 16 bit
  localparam int ADDR_W      = 16;   // APB address
  localparam int LCD_ADDR_W  = 11;   // Shared RAM address register
  localparam int FONT_DEPTH  = 1024; // 128 glyphs x 8 rows
  localparam int FONT_ADDR_W = $clog2(FONT_DEPTH);
  localparam int GLYPH_W     = 8;    // Glyph is 8x8 pixels

  // Misc page selector, paddr[7:4] when paddr[11] is set
  // Selects 0 and 1 are left free
  typedef enum logic [3:0] {
    SEL_LCD_ADDR = 4'd2,  // Shared RAM address
    SEL_FONT     = 4'd3,  // Font byte at address
    SEL_TEXT     = 4'd4,  // Character byte at address
    SEL_FG0      = 4'd5,
    SEL_BG0      = 4'd6,
    SEL_FG1      = 4'd7,
    SEL_BG1      = 4'd8,
    SEL_LCD_CTRL = 4'd9,  // Control on write, status on read
    SEL_LCD_DATA = 4'd10  // Write only byte port
  } io_sel_e;

  // Write modes for GPIO registers, paddr[1:0]
  typedef enum logic [1:0] {
    OP_WRITE,
    OP_CLEAR,
    OP_SET,
    OP_TOGGLE
  } bit_op_e;

  // Who owns which RAM this cycle
  typedef enum logic {
    SLOT_CHAR_RENDER, // Renderer on text RAM, bus on font RAM
    SLOT_FONT_RENDER  // Renderer on font RAM, bus on text RAM
  } ram_slot_e;

  typedef enum logic [1:0] {
    ST_IDLE, // Software bytes pass through
    ST_ARM,  // Waiting for slot boundary
    ST_PUSH  // Streaming the frame
  } lcd_state_e;

  // RGB565 colours after reset
  localparam logic [DATA_W-1:0] FG0_RESET = 16'hFD20; // Orange
  localparam logic [DATA_W-1:0] BG0_RESET = 16'h000F; // Navy
  localparam logic [DATA_W-1:0] FG1_RESET = 16'h07FF; // Cyan
  localparam logic [DATA_W-1:0] BG1_RESET = 16'h000F; // Navy

  // LCD commands
  localparam logic [7:0] CMD_NOP   = 8'h00;
  localparam logic [7:0] CMD_RAMWR = 8'h2C;

endpackage

// File: source/io_regs.sv
`timescale 1ns/100ps

module io_regs import badge_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_button,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [ADDR_W-1:0]     paddr,
  input  logic [DATA_W-1:0]     pwdata,
  input  logic [7:0]            gpio_in,
  input  logic                  lcd_mode,
  input  logic                  updating,
  input  logic                  fmark_synced,
  input  logic                  ram_done,
  input  logic [7:0]            ram_rdata,
  output logic [DATA_W-1:0]     prdata,
  output logic                  pready,
  output logic                  irq,
  output logic [7:0]            gpio_out,
  output logic [7:0]            gpio_dir,
  output logic                  lcd_cs_n,
  output logic                  lcd_rst_n,
  output logic                  ram_req,
  output logic                  ram_we,
  output logic                  ram_font,
  output logic [LCD_ADDR_W-1:0] ram_addr,
  output logic [7:0]            ram_wdata,
  output logic                  sw_lcd_wr,
  output logic [8:0]            sw_lcd_byte,
  output logic [DATA_W-1:0]     color_fg0,
  output logic [DATA_W-1:0]     color_bg0,
  output logic [DATA_W-1:0]     color_fg1,
  output logic [DATA_W-1:0]     color_bg1
);

  logic                  access;       // APB access phase
  logic                  wr_en;        // Register write on this edge
  logic                  misc;         // Misc page hit
  io_sel_e               sel;
  bit_op_e               op;
  logic                  ram_sel;      // Font or text access
  logic                  tick_wr;
  logic [DATA_W:0]       ticks_plus_1; // Extra bit is the wrap
  logic [DATA_W-1:0]     ticks;
  logic [DATA_W-1:0]     cycles;
  logic [1:0]            lcd_ctrl;     // {rst_n, cs_n}
  logic [LCD_ADDR_W-1:0] lcd_addr;

  // Apply a write mode to an 8-bit register
  function automatic logic [7:0] apply_op(input logic [7:0] cur, input logic [7:0] val,
                                          input bit_op_e mode);
    case (mode)
      OP_CLEAR:  return cur & ~val;
      OP_SET:    return cur | val;
      OP_TOGGLE: return cur ^ val;
      default:   return val;
    endcase
  endfunction

  assign access  = psel & penable;
  assign wr_en   = access & pwrite;
  assign misc    = paddr[11];
  assign sel     = io_sel_e'(paddr[7:4]);
  assign op      = bit_op_e'(paddr[1:0]);
  assign ram_sel = misc & ((sel == SEL_FONT) | (sel == SEL_TEXT));
  assign tick_wr = wr_en & paddr[14];

  // RAM request already in setup, so a lucky slot finishes in one access cycle
  assign ram_req   = psel & ram_sel;
  assign ram_we    = pwrite;
  assign ram_font  = (sel == SEL_FONT);
  assign ram_addr  = lcd_addr;
  assign ram_wdata = pwdata[7:0];

  assign pready = access & (~ram_sel | ram_done); // RAM waits for the arbiter

  // Bit 8 of the written word means command, so rs is its inverse
  assign sw_lcd_wr   = wr_en & misc & (sel == SEL_LCD_DATA);
  assign sw_lcd_byte = pwdata[8:0] ^ 9'h100;

  assign {lcd_rst_n, lcd_cs_n} = lcd_ctrl;

  assign ticks_plus_1 = {1'b0, ticks} + 1'b1;

  always_ff @(posedge clk) begin
    if (reset_button) begin
      gpio_out  <= '0;
      gpio_dir  <= '0;
      ticks     <= '0;
      cycles    <= '0;
      irq       <= 1'b0;
      lcd_ctrl  <= 2'b01;  // Chip deselected, panel held in reset
      lcd_addr  <= '0;
      color_fg0 <= FG0_RESET;
      color_bg0 <= BG0_RESET;
      color_fg1 <= FG1_RESET;
      color_bg1 <= BG1_RESET;
    end else begin
      cycles <= cycles + 1'b1; // Free running
      ticks  <= tick_wr ? pwdata : ticks_plus_1[DATA_W-1:0];
      irq    <= ticks_plus_1[DATA_W] & ~tick_wr; // One cycle on wrap

      if (wr_en & paddr[9])  gpio_out <= apply_op(gpio_out, pwdata[7:0], op);
      if (wr_en & paddr[10]) gpio_dir <= apply_op(gpio_dir, pwdata[7:0], op);

      if (wr_en & misc) begin
        case (sel)
          SEL_LCD_ADDR: lcd_addr  <= pwdata[LCD_ADDR_W-1:0];
          SEL_FG0:      color_fg0 <= pwdata;
          SEL_BG0:      color_bg0 <= pwdata;
          SEL_FG1:      color_fg1 <= pwdata;
          SEL_BG1:      color_bg1 <= pwdata;
          SEL_LCD_CTRL: lcd_ctrl  <= pwdata[1:0];
          default:      ; // Font, text and LCD data go elsewhere
        endcase
      end
    end
  end

  // Read mux, every selected source ORed in
  always_comb begin
    prdata = '0;
    if (paddr[8])  prdata = prdata | DATA_W'(gpio_in);
    if (paddr[9])  prdata = prdata | DATA_W'(gpio_out);
    if (paddr[10]) prdata = prdata | DATA_W'(gpio_dir);
    if (paddr[14]) prdata = prdata | ticks;
    if (paddr[15]) prdata = prdata | cycles;
    if (misc) begin
      case (sel)
        SEL_LCD_ADDR: prdata = prdata | DATA_W'(lcd_addr);
        SEL_FONT,
        SEL_TEXT:     if (ram_done) prdata = prdata | DATA_W'(ram_rdata); // Zero while waiting
        SEL_FG0:      prdata = prdata | color_fg0;
        SEL_BG0:      prdata = prdata | color_bg0;
        SEL_FG1:      prdata = prdata | color_fg1;
        SEL_BG1:      prdata = prdata | color_bg1;
        SEL_LCD_CTRL: prdata = prdata | DATA_W'({updating, fmark_synced, lcd_mode, lcd_ctrl});
        default:      ;
      endcase
    end
  end

endmodule

// File: source/text_ram_arbiter.sv
`timescale 1ns/100ps

module text_ram_arbiter import badge_pkg::*; #(
  parameter int SCREEN_COLS = 40,
  parameter int SCREEN_ROWS = 30
) (
  input  logic                   clk,
  input  logic                   reset_button,
  input  logic                   ram_req,    // Held until ram_done
  input  logic                   ram_we,
  input  logic                   ram_font,   // 1 font RAM, 0 text RAM
  input  logic [LCD_ADDR_W-1:0]  ram_addr,
  input  logic [7:0]             ram_wdata,
  input  logic [LCD_ADDR_W-1:0]  char_index,
  input  logic [FONT_ADDR_W-1:0] glyph_addr,
  output logic                   ram_done,
  output logic [7:0]             ram_rdata,
  output logic [7:0]             char_code,  // Valid after a char slot
  output logic [7:0]             glyph_row   // Valid after a font slot
);

  localparam int TEXT_DEPTH = SCREEN_COLS * SCREEN_ROWS;
  localparam int TEXT_AW    = $clog2(TEXT_DEPTH);

  logic [7:0] char_mem [TEXT_DEPTH];
  logic [7:0] font_mem [FONT_DEPTH];

  ram_slot_e              slot;
  logic                   bus_owns;  // Bus may use the RAM it asks for
  logic                   serve;
  logic                   text_hit;  // Text address inside the screen
  logic [FONT_ADDR_W-1:0] font_addr;
  logic [TEXT_AW-1:0]     text_addr;
  logic [TEXT_AW-1:0]     render_addr;

  assign bus_owns = ram_font ? (slot == SLOT_CHAR_RENDER) : (slot == SLOT_FONT_RENDER);
  assign serve    = ram_req & bus_owns;
  assign text_hit = int'(ram_addr) < TEXT_DEPTH;

  assign font_addr   = ram_addr[FONT_ADDR_W-1:0];
  assign text_addr   = ram_addr[TEXT_AW-1:0];
  assign render_addr = char_index[TEXT_AW-1:0]; // Renderer stays on screen

  always_ff @(posedge clk) begin
    if (reset_button) begin
      slot     <= SLOT_CHAR_RENDER; // Renderer starts in step with this
      ram_done <= 1'b0;
    end else begin
      slot     <= (slot == SLOT_CHAR_RENDER) ? SLOT_FONT_RENDER : SLOT_CHAR_RENDER;
      ram_done <= serve; // Cycle after the access
    end
  end

  // One port per RAM per cycle, owner picked by slot
  always_ff @(posedge clk) begin
    if (slot == SLOT_CHAR_RENDER) begin
      char_code <= char_mem[render_addr];
      if (serve) begin
        if (ram_we) font_mem[font_addr] <= ram_wdata;
        ram_rdata <= font_mem[font_addr];
      end
    end else begin
      glyph_row <= font_mem[glyph_addr];
      if (serve) begin
        if (ram_we && text_hit) char_mem[text_addr] <= ram_wdata; // Off screen dropped
        ram_rdata <= text_hit ? char_mem[text_addr] : 8'h00;
      end
    end
  end

endmodule

// File: source/lcd_text_renderer.sv
`timescale 1ns/100ps

module lcd_text_renderer import badge_pkg::*; #(
  parameter int SCREEN_COLS = 40,
  parameter int SCREEN_ROWS = 30
) (
  input  logic                   clk,
  input  logic                   reset_button,
  input  logic                   lcd_fmark,    // Asynchronous frame mark
  input  logic [7:0]             char_code,
  input  logic [7:0]             glyph_row,
  input  logic [DATA_W-1:0]      color_fg0,
  input  logic [DATA_W-1:0]      color_bg0,
  input  logic [DATA_W-1:0]      color_fg1,
  input  logic [DATA_W-1:0]      color_bg1,
  input  logic                   sw_lcd_wr,
  input  logic [8:0]             sw_lcd_byte,  // {rs, data}
  output logic [LCD_ADDR_W-1:0]  char_index,
  output logic [FONT_ADDR_W-1:0] glyph_addr,
  output logic                   updating,
  output logic                   fmark_synced,
  output logic [7:0]             lcd_d,
  output logic                   lcd_rs,
  output logic                   lcd_wr
);

  localparam int PIX_W  = SCREEN_COLS * GLYPH_W;
  localparam int PIX_H  = SCREEN_ROWS * GLYPH_W;
  localparam int X_W    = $clog2(PIX_W);
  localparam int Y_W    = $clog2(PIX_H);
  localparam int G_BITS = $clog2(GLYPH_W);

  lcd_state_e        state;
  ram_slot_e         phase;      // Mirrors the arbiter slot
  logic              fmark_sync1;
  logic [X_W-1:0]    x;          // Pixel being fetched
  logic [Y_W-1:0]    y;
  logic              scan_done;  // Last pixel fetched
  logic              hdr;        // Still sending NOP and RAMWR
  logic [G_BITS-1:0] x_lo_d;     // Column inside glyph, one slot later
  logic [7:0]        lo_pend;    // Low colour byte waiting its turn
  logic [DATA_W-1:0] pix_color;

  assign updating = (state != ST_IDLE);

  // Text cell of this pixel, then the glyph row of its code
  assign char_index = LCD_ADDR_W'(x >> G_BITS) + LCD_ADDR_W'(SCREEN_COLS * (y >> G_BITS));
  assign glyph_addr = {char_code[6:0], y[G_BITS-1:0]};

  // Leftmost pixel is glyph bit 7, code bit 7 picks colour set 1
  always_comb begin
    if (glyph_row[~x_lo_d])
      pix_color = char_code[7] ? color_fg1 : color_fg0;
    else
      pix_color = char_code[7] ? color_bg1 : color_bg0;
  end

  always_ff @(posedge clk) begin
    if (reset_button) begin
      fmark_sync1  <= 1'b0;
      fmark_synced <= 1'b0;
      phase        <= SLOT_CHAR_RENDER;
      state        <= ST_IDLE;
      x            <= '0;
      y            <= '0;
      scan_done    <= 1'b0;
      hdr          <= 1'b0;
      lcd_wr       <= 1'b0;
    end else begin
      fmark_sync1  <= lcd_fmark;   // Two flop synchroniser
      fmark_synced <= fmark_sync1;
      phase        <= (phase == SLOT_CHAR_RENDER) ? SLOT_FONT_RENDER : SLOT_CHAR_RENDER;
      lcd_wr       <= 1'b0;
      case (state)
        ST_IDLE: begin
          lcd_wr <= sw_lcd_wr; // Software byte port
          if (fmark_synced) state <= ST_ARM;
        end
        ST_ARM: begin
          x         <= '0;
          y         <= '0;
          scan_done <= 1'b0;
          hdr       <= 1'b1;
          if (phase == SLOT_FONT_RENDER) state <= ST_PUSH; // First push cycle is a char slot
        end
        ST_PUSH: begin
          lcd_wr <= 1'b1; // Byte every cycle
          if (phase == SLOT_FONT_RENDER) begin
            hdr <= 1'b0;
            if (scan_done) begin
              state <= ST_IDLE; // Last low byte going out
            end else if (y == Y_W'(PIX_H - 1)) begin
              y <= '0;       // Column done
              if (x == X_W'(PIX_W - 1)) scan_done <= 1'b1;
              else x <= x + 1'b1;
            end else begin
              y <= y + 1'b1; // Column major, y fastest
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Byte pipeline, high byte in char slot, low byte in font slot
  always_ff @(posedge clk) begin
    if (state == ST_PUSH) begin
      if (phase == SLOT_CHAR_RENDER) begin
        {lcd_rs, lcd_d} <= hdr ? {1'b0, CMD_NOP} : {1'b1, pix_color[15:8]};
        lo_pend         <= pix_color[7:0];
      end else begin
        {lcd_rs, lcd_d} <= hdr ? {1'b0, CMD_RAMWR} : {1'b1, lo_pend};
        x_lo_d          <= x[G_BITS-1:0]; // Glyph row lands next cycle
      end
    end else if (state == ST_IDLE && sw_lcd_wr) begin
      {lcd_rs, lcd_d} <= sw_lcd_byte; // Dropped while updating
    end
  end

endmodule

// File: source/badge_io.sv
`timescale 1ns/100ps

module badge_io import badge_pkg::*; #(
  parameter int SCREEN_COLS = 40, // Text columns
  parameter int SCREEN_ROWS = 30  // Text rows
) (
  input  logic              clk,
  input  logic              reset_button,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output logic              irq,      // Tick wrap
  input  logic [7:0]        gpio_in,
  output logic [7:0]        gpio_out,
  output logic [7:0]        gpio_dir, // 1 drives the pin
  output logic [7:0]        lcd_d,
  output logic              lcd_rs,   // Low for command
  output logic              lcd_wr,   // Active high strobe
  output logic              lcd_cs_n,
  output logic              lcd_rst_n,
  input  logic              lcd_fmark,
  input  logic              lcd_mode
);

  // Register file to RAM arbiter
  logic                   ram_req;
  logic                   ram_we;
  logic                   ram_font;
  logic [LCD_ADDR_W-1:0]  ram_addr;
  logic [7:0]             ram_wdata;
  logic                   ram_done;
  logic [7:0]             ram_rdata;

  // Renderer to RAM arbiter
  logic [LCD_ADDR_W-1:0]  char_index;
  logic [7:0]             char_code;
  logic [FONT_ADDR_W-1:0] glyph_addr;
  logic [7:0]             glyph_row;

  // Register file to renderer
  logic                   sw_lcd_wr;
  logic [8:0]             sw_lcd_byte; // {rs, data}
  logic [DATA_W-1:0]      color_fg0;
  logic [DATA_W-1:0]      color_bg0;
  logic [DATA_W-1:0]      color_fg1;
  logic [DATA_W-1:0]      color_bg1;
  logic                   updating;
  logic                   fmark_synced;

  io_regs regs (.*);

  text_ram_arbiter #(.SCREEN_COLS(SCREEN_COLS), .SCREEN_ROWS(SCREEN_ROWS)) arbiter (.*);

  lcd_text_renderer #(.SCREEN_COLS(SCREEN_COLS), .SCREEN_ROWS(SCREEN_ROWS)) renderer (.*);

endmodule

// File: test/badge_io_checker.sv
`timescale 1ns/100ps

module badge_io_checker (
  input logic        clk,
  input logic        reset_button,
  input logic        psel,
  input logic        penable,
  input logic [15:0] paddr,
  input logic [15:0] prdata,
  input logic        pready,
  input logic        irq,
  input logic        lcd_wr
);

  // pready only inside an access phase
  ready_in_access: assert property (@(posedge clk) disable iff (reset_button)
    pready |-> psel && penable)
    else $error("pready high outside an APB access phase");

  irq_single: assert property (@(posedge clk) disable iff (reset_button) irq |=> !irq)
    else $error("irq high on two cycles in a row");

  strobe_reset: assert property (@(posedge clk) reset_button |=> !lcd_wr)
    else $error("lcd_wr high right after reset");

  // Waiting access keeps address and read data
  wait_stable: assert property (@(posedge clk) disable iff (reset_button)
    psel && penable && !pready |=> $stable(paddr) && (pready || $stable(prdata)))
    else $error("paddr or prdata moved while an access waited");

endmodule

bind badge_io badge_io_checker protocol_check (.*);

// File: test/badge_io_tb.sv
`timescale 1ns/100ps

module badge_io_tb;

  localparam int COLS        = 4;      // Small screen, 32 x 24 pixels
  localparam int ROWS        = 3;
  localparam int PIX_W       = COLS * 8;
  localparam int PIX_H       = ROWS * 8;
  localparam int READY_LIMIT = 16;     // Access cycles allowed per transfer
  localparam int FRAME_LIMIT = 4000;   // Cycles allowed for one frame
  localparam int WATCHDOG_NS = 500000;

  localparam logic [15:0] GPIO_IN_ADDR  = 16'h0100;
  localparam logic [15:0] GPIO_OUT_ADDR = 16'h0200; // Low two bits pick the write mode
  localparam logic [15:0] GPIO_DIR_ADDR = 16'h0400;
  localparam logic [15:0] LCD_ADDR_ADDR = 16'h0820;
  localparam logic [15:0] FONT_ADDR     = 16'h0830;
  localparam logic [15:0] TEXT_ADDR     = 16'h0840;
  localparam logic [15:0] FG0_ADDR      = 16'h0850; // BG0, FG1, BG1 follow in steps of 0x10
  localparam logic [15:0] LCD_CTRL_ADDR = 16'h0890;
  localparam logic [15:0] LCD_DATA_ADDR = 16'h08A0;
  localparam logic [15:0] TICKS_ADDR    = 16'h4000;
  localparam logic [15:0] CYCLES_ADDR   = 16'h8000;

  logic        clk = 1'b0;
  logic        reset_button;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        pready;
  logic        irq;
  logic [7:0]  gpio_in;
  logic [7:0]  gpio_out;
  logic [7:0]  gpio_dir;
  logic [7:0]  lcd_d;
  logic        lcd_rs;
  logic        lcd_wr;
  logic        lcd_cs_n;
  logic        lcd_rst_n;
  logic        lcd_fmark;
  logic        lcd_mode;

  int          errors = 0;
  int          errors_at_start = 0;
  int          test_num = 0;
  int          tests_failed = 0;
  int          clk_count = 0;
  int          access_clk;            // Clock count at the last access sample
  logic [8:0]  exp_q[$];              // {rs, data} still owed by the LCD port
  logic [8:0]  exp_byte;
  logic [7:0]  font_sh [1024];
  logic [7:0]  text_sh [COLS*ROWS];
  logic [15:0] color_sh [4];          // FG0, BG0, FG1, BG1

  badge_io #(.SCREEN_COLS(COLS), .SCREEN_ROWS(ROWS)) uut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) clk_count <= clk_count + 1;

  // Expected RGB565 word of pixel (x, y), high byte goes out first
  function automatic logic [15:0] pixel_bytes(input int x, input int y);
    logic [7:0] code;
    logic [7:0] row;
    logic       lit;
    code = text_sh[(x / 8) + COLS * (y / 8)];
    row  = font_sh[int'(code[6:0]) * 8 + (y % 8)];
    lit  = row[7 - (x % 8)];       // Leftmost pixel is the glyph MSB
    if (code[7])
      return lit ? color_sh[2] : color_sh[3];
    return lit ? color_sh[0] : color_sh[1];
  endfunction

  function automatic logic [7:0] bit_op_model(input logic [7:0] cur, input logic [7:0] val,
                                              input int op);
    case (op)
      0: return val;
      1: return cur & ~val;
      2: return cur | val;
      default: return cur ^ val;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] got);
    $display("ERROR %s: expected %h, got %h", name, exp, got);
    errors++;
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", test_num, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // Access phase up to the edge where pready ends it
  task automatic run_access(output logic [15:0] data);
    int n;
    n = 0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (pready !== 1'b1 && n < READY_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (pready !== 1'b1) begin
      $display("Transfer to address %h never saw pready", paddr);
      errors++;
    end
    data       = prdata;
    access_clk = clk_count;
    @(posedge clk);                // Transfer completes here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
    logic [15:0] ignored;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    run_access(ignored);
  endtask

  task automatic read_reg(input logic [15:0] addr, output logic [15:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    run_access(data);
  endtask

  task automatic ram_write(input logic font, input int addr, input logic [7:0] data);
    write_reg(LCD_ADDR_ADDR, 16'(addr));
    write_reg(font ? FONT_ADDR : TEXT_ADDR, {8'h00, data});
  endtask

  task automatic ram_read(input logic font, input int addr, output logic [15:0] data);
    write_reg(LCD_ADDR_ADDR, 16'(addr));
    read_reg(font ? FONT_ADDR : TEXT_ADDR, data);
  endtask

  task automatic wait_lcd_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("LCD port stopped with %0d expected bytes never written", exp_q.size());
      errors++;
      exp_q.delete();
    end
    repeat (8) @(negedge clk);     // Room for stray strobes
  endtask

  // Every strobe must match the next expected byte
  always @(negedge clk) begin
    if (reset_button === 1'b0 && lcd_wr === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected LCD write of %h with lcd_rs %b", lcd_d, lcd_rs);
        errors++;
      end else begin
        exp_byte = exp_q.pop_front();
        if (lcd_rs !== exp_byte[8]) report_mismatch("lcd_rs", 16'(exp_byte[8]), 16'(lcd_rs));
        if (lcd_d !== exp_byte[7:0]) report_mismatch("lcd_d", 16'(exp_byte[7:0]), 16'(lcd_d));
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run stopped by the watchdog timer");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [15:0] rd;
    logic [15:0] c1;
    logic [15:0] pix;
    logic [7:0]  val;
    logic [7:0]  shadow_out;
    logic [7:0]  shadow_dir;
    int          op;
    int          t1;
    int          n;
    int          font_list [16];
    void'($urandom(45));
    reset_button = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = 16'h0000;
    pwdata       = 16'h0000;
    gpio_in      = 8'h00;
    lcd_fmark    = 1'b0;
    lcd_mode     = 1'b1;
    color_sh[0]  = 16'hFD20;       // Orange
    color_sh[1]  = 16'h000F;       // Navy
    color_sh[2]  = 16'h07FF;       // Cyan
    color_sh[3]  = 16'h000F;
    repeat (2) @(posedge clk);
    reset_button <= 1'b0;

    for (int i = 0; i < 4; i++) begin
      read_reg(FG0_ADDR + 16'(i * 16), rd);
      if (rd !== color_sh[i]) report_mismatch("prdata colour", color_sh[i], rd);
    end
    @(negedge clk);
    if (lcd_cs_n !== 1'b1) report_mismatch("lcd_cs_n", 16'h1, 16'(lcd_cs_n));
    if (lcd_rst_n !== 1'b0) report_mismatch("lcd_rst_n", 16'h0, 16'(lcd_rst_n));
    if (gpio_out !== 8'h00) report_mismatch("gpio_out", 16'h0, 16'(gpio_out));
    if (gpio_dir !== 8'h00) report_mismatch("gpio_dir", 16'h0, 16'(gpio_dir));
    write_reg(LCD_CTRL_ADDR, 16'h0002); // Panel out of reset, chip selected
    @(negedge clk);
    if (lcd_cs_n !== 1'b0) report_mismatch("lcd_cs_n", 16'h0, 16'(lcd_cs_n));
    if (lcd_rst_n !== 1'b1) report_mismatch("lcd_rst_n", 16'h1, 16'(lcd_rst_n));
    read_reg(LCD_CTRL_ADDR, rd);
    if (rd !== 16'h0006) report_mismatch("prdata status", 16'h0006, rd);
    end_test("reset values");

    shadow_out = 8'h00;
    shadow_dir = 8'h00;
    for (int i = 0; i < 24; i++) begin
      op  = int'($urandom % 4);
      val = 8'($urandom);
      if ($urandom % 2 == 0) begin
        write_reg(GPIO_OUT_ADDR | 16'(op), {8'h00, val});
        shadow_out = bit_op_model(shadow_out, val, op);
      end else begin
        write_reg(GPIO_DIR_ADDR | 16'(op), {8'h00, val});
        shadow_dir = bit_op_model(shadow_dir, val, op);
      end
      @(negedge clk);
      if (gpio_out !== shadow_out) report_mismatch("gpio_out", 16'(shadow_out), 16'(gpio_out));
      if (gpio_dir !== shadow_dir) report_mismatch("gpio_dir", 16'(shadow_dir), 16'(gpio_dir));
    end
    read_reg(GPIO_OUT_ADDR, rd);
    if (rd !== {8'h00, shadow_out}) report_mismatch("prdata gpio_out", 16'(shadow_out), rd);
    read_reg(GPIO_DIR_ADDR, rd);
    if (rd !== {8'h00, shadow_dir}) report_mismatch("prdata gpio_dir", 16'(shadow_dir), rd);
    val = 8'($urandom);
    @(posedge clk);
    gpio_in <= val;
    read_reg(GPIO_IN_ADDR, rd);
    if (rd !== {8'h00, val}) report_mismatch("prdata gpio_in", 16'(val), rd);
    end_test("GPIO modes");

    for (int i = 0; i < 16; i++) begin
      font_list[i] = int'($urandom % 1024);
      val = 8'($urandom);
      ram_write(1'b1, font_list[i], val);
      font_sh[font_list[i]] = val;
    end
    for (int i = 0; i < 16; i++) begin
      ram_read(1'b1, font_list[i], rd);
      if (rd !== {8'h00, font_sh[font_list[i]]})
        report_mismatch("prdata font", 16'(font_sh[font_list[i]]), rd);
    end
    for (int i = 0; i < COLS * ROWS; i++) begin
      text_sh[i] = 8'($urandom);
      ram_write(1'b0, i, text_sh[i]);
    end
    for (int i = 0; i < COLS * ROWS; i++) begin
      ram_read(1'b0, i, rd);
      if (rd !== {8'h00, text_sh[i]}) report_mismatch("prdata text", 16'(text_sh[i]), rd);
    end
    end_test("shared RAM");

    read_reg(CYCLES_ADDR, c1);
    t1 = access_clk;
    repeat (3 + $urandom % 40) @(posedge clk);
    read_reg(CYCLES_ADDR, rd);
    if (rd !== c1 + 16'(access_clk - t1))
      report_mismatch("prdata cycles", c1 + 16'(access_clk - t1), rd);
    write_reg(TICKS_ADDR, 16'hFFF0);
    n = 0;
    while (irq !== 1'b1 && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (irq !== 1'b1) begin
      $display("No irq within 40 cycles of setting ticks");
      errors++;
    end
    read_reg(TICKS_ADDR, rd);
    if (rd >= 16'd64) report_mismatch("prdata ticks", 16'd64, rd);
    end_test("counters");

    // Codes use glyphs 0 to 3, bit 7 picks the colour set
    for (int i = 0; i < COLS * ROWS; i++) begin
      text_sh[i] = {1'($urandom), 5'b00000, 2'($urandom)};
      ram_write(1'b0, i, text_sh[i]);
    end
    for (int i = 0; i < 32; i++) begin
      font_sh[i] = 8'($urandom);
      ram_write(1'b1, i, font_sh[i]);
    end
    for (int i = 0; i < 4; i++) begin
      color_sh[i] = 16'($urandom);
      write_reg(FG0_ADDR + 16'(i * 16), color_sh[i]);
    end
    exp_q.push_back({1'b0, 8'h00}); // NOP
    exp_q.push_back({1'b0, 8'h2C}); // RAMWR
    for (int x = 0; x < PIX_W; x++) begin
      for (int y = 0; y < PIX_H; y++) begin
        pix = pixel_bytes(x, y);
        exp_q.push_back({1'b1, pix[15:8]});
        exp_q.push_back({1'b1, pix[7:0]});
      end
    end
    @(posedge clk);
    lcd_fmark <= 1'b1;
    repeat (3) @(posedge clk);
    lcd_fmark <= 1'b0;
    repeat (10) @(posedge clk);
    read_reg(LCD_CTRL_ADDR, rd);
    if (rd[4] !== 1'b1) report_mismatch("updating", 16'h0001, 16'(rd[4]));
    wait_lcd_drain(FRAME_LIMIT);
    read_reg(LCD_CTRL_ADDR, rd);
    if (rd[4] !== 1'b0) report_mismatch("updating", 16'h0000, 16'(rd[4]));
    end_test("frame render");

    exp_q.push_back({1'b0, 8'hA5}); // Bit 8 set means command
    write_reg(LCD_DATA_ADDR, 16'h01A5);
    exp_q.push_back({1'b1, 8'h5A});
    write_reg(LCD_DATA_ADDR, 16'h005A);
    wait_lcd_drain(20);
    end_test("software LCD writes");

    $display("%0d tests run, %0d failed, %0d errors", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: badge_io.f
source/badge_pkg.sv
source/io_regs.sv
source/text_ram_arbiter.sv
source/lcd_text_renderer.sv
source/badge_io.sv
test/badge_io_checker.sv
test/badge_io_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= badge_io_tb
RTL_TOP    ?= badge_io
FILELIST   ?= badge_io.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Some tests failed
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  := $(filter source/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
